/* common/sched_pkg.sv */
// widths and counts shared by the scheduler RTL and its testbench
// physical register count must be a power of two so the free-list pointers wrap
// physical register 0 is permanently bound to architectural register 0
package sched_pkg;

  // ================================================
  // register file sizes
  // ================================================
  localparam int ARCH_REG_NUM = 32;
  localparam int PHY_REG_NUM  = 64;

  // writeback broadcast lanes seen by rename and dispatch
  localparam int WB_WIDTH = 2;

  // ================================================
  // vector types
  // ================================================
  // architectural register number
  typedef logic [$clog2(ARCH_REG_NUM)-1:0] arch_reg_t;

  // physical register number
  typedef logic [$clog2(PHY_REG_NUM)-1:0] preg_t;

  // free-list occupancy, 0 up to PHY_REG_NUM inclusive
  typedef logic [$clog2(PHY_REG_NUM+1)-1:0] fl_cnt_t;

  // operation tag, opaque to the scheduler
  typedef logic [15:0] op_tag_t;

  // one valid bit per writeback lane
  typedef logic [WB_WIDTH-1:0] wb_valid_t;

endpackage

/* common/rename_if.sv */
// one renamed entry moving from the rename stage into the dispatch queue
// valid/ready handshake, payload held by the source while ready is low
`timescale 1ns/1ps

interface rename_if;
  import sched_pkg::*;

  logic    valid;
  logic    ready;
  preg_t   psrc0;
  preg_t   psrc1;
  preg_t   pdest;
  preg_t   old_pdest;
  logic    dest_valid;
  op_tag_t tag;
  // source readiness at transfer time, writeback bypass included
  logic    src0_rdy;
  logic    src1_rdy;

  modport src (output valid, psrc0, psrc1, pdest, old_pdest, dest_valid, tag,
               output src0_rdy, src1_rdy, input ready);

  modport dst (input valid, psrc0, psrc1, pdest, old_pdest, dest_valid, tag,
               input src0_rdy, src1_rdy, output ready);

endinterface

/* rename/free_list.sv */
// FIFO of free physical registers, holds 32..63 ascending after reset
// alloc_i must only be raised while alloc_ready_o is high
// commit must never free more registers than the list can hold
`timescale 1ns/1ps

module free_list (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             alloc_i,
  output logic             alloc_ready_o,
  output sched_pkg::preg_t alloc_preg_o,
  input  logic             free_valid_i,
  input  sched_pkg::preg_t free_preg_i
);
  import sched_pkg::*;

  localparam int PW = $clog2(PHY_REG_NUM);
  localparam int INIT_FREE = PHY_REG_NUM - ARCH_REG_NUM;

  preg_t         list_q [PHY_REG_NUM];
  logic [PW-1:0] head_q;
  logic [PW-1:0] tail_q;
  fl_cnt_t       cnt_q;

  // allocation straight from the head, popped on the accept edge
  assign alloc_ready_o = (cnt_q != '0);
  assign alloc_preg_o  = list_q[head_q];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // entries above the initial tail are overwritten before they are read
      for (int i = 0; i < PHY_REG_NUM; i++) begin
        list_q[i] <= preg_t'(INIT_FREE + i);
      end
      head_q <= '0;
      tail_q <= PW'(INIT_FREE);
      cnt_q  <= fl_cnt_t'(INIT_FREE);
    end else begin
      if (alloc_i) begin
        head_q <= head_q + 1'b1;
      end
      if (free_valid_i) begin
        list_q[tail_q] <= free_preg_i;
        tail_q         <= tail_q + 1'b1;
      end
      case ({free_valid_i, alloc_i})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // rename stage must see ready before popping
  a_no_alloc_empty: assert property (
    @(posedge clk) disable iff (!rst_n) alloc_i |-> cnt_q != '0
  );

  // commit side has no ready, so an overflow means a double free upstream
  a_no_free_full: assert property (
    @(posedge clk) disable iff (!rst_n)
    free_valid_i |-> cnt_q != fl_cnt_t'(PHY_REG_NUM)
  );

endmodule

/* rename/register_alias_table.sv */
// architectural to physical map plus one busy bit per physical register
// lookups are combinational, updates and writebacks land on the clock edge
// architectural register 0 stays bound to physical register 0
`timescale 1ns/1ps

module register_alias_table (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  sched_pkg::arch_reg_t                        src0_i,
  input  sched_pkg::arch_reg_t                        src1_i,
  input  sched_pkg::arch_reg_t                        dest_i,
  input  logic                                        update_i,
  input  sched_pkg::preg_t                            new_preg_i,
  input  sched_pkg::wb_valid_t                        wb_valid_i,
  input  sched_pkg::preg_t [sched_pkg::WB_WIDTH-1:0]  wb_preg_i,
  output sched_pkg::preg_t                            psrc0_o,
  output sched_pkg::preg_t                            psrc1_o,
  output sched_pkg::preg_t                            old_pdest_o,
  output logic                                        psrc0_busy_o,
  output logic                                        psrc1_busy_o
);
  import sched_pkg::*;

  preg_t                  map_q [ARCH_REG_NUM];
  logic [PHY_REG_NUM-1:0] busy_q;

  // ================================================
  // lookup
  // ================================================
  assign psrc0_o     = map_q[src0_i];
  assign psrc1_o     = map_q[src1_i];
  assign old_pdest_o = map_q[dest_i];

  // busy as of the start of this cycle, bypass is handled by the caller
  assign psrc0_busy_o = busy_q[psrc0_o];
  assign psrc1_busy_o = busy_q[psrc1_o];

  // ================================================
  // map and busy update
  // ================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // identity mapping, nothing in flight
      for (int r = 0; r < ARCH_REG_NUM; r++) begin
        map_q[r] <= preg_t'(r);
      end
      busy_q <= '0;
    end else begin
      for (int j = 0; j < WB_WIDTH; j++) begin
        if (wb_valid_i[j]) begin
          busy_q[wb_preg_i[j]] <= 1'b0;
        end
      end
      // a freshly allocated register cannot be written back yet,
      // so the set below never races a clear
      if (update_i) begin
        map_q[dest_i]      <= new_preg_i;
        busy_q[new_preg_i] <= 1'b1;
      end
    end
  end

  // r0 is hardwired, the rename stage must never retarget it
  a_no_update_r0: assert property (
    @(posedge clk) disable iff (!rst_n) update_i |-> dest_i != '0
  );

endmodule

/* rename/rename_stage.sv */
// single-entry rename register between the request port and the dispatch queue
// a nonzero destination takes a physical register on the accept edge
// the alias table is written only when the entry moves into the queue
`timescale 1ns/1ps

module rename_stage (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        req_valid_i,
  output logic                                        req_ready_o,
  input  sched_pkg::arch_reg_t                        req_src0_i,
  input  sched_pkg::arch_reg_t                        req_src1_i,
  input  sched_pkg::arch_reg_t                        req_dest_i,
  input  sched_pkg::op_tag_t                          req_tag_i,
  input  sched_pkg::wb_valid_t                        wb_valid_i,
  input  sched_pkg::preg_t [sched_pkg::WB_WIDTH-1:0]  wb_preg_i,
  input  logic                                        free_valid_i,
  input  sched_pkg::preg_t                            free_preg_i,
  rename_if.src                                       ren_o
);
  import sched_pkg::*;

  logic      valid_q;
  arch_reg_t src0_q;
  arch_reg_t src1_q;
  arch_reg_t dest_q;
  op_tag_t   tag_q;
  preg_t     pdest_q;

  logic      accept;
  logic      fire_out;
  logic      dest_nz;
  logic      fl_ready;
  preg_t     fl_preg;
  preg_t     rat_psrc0;
  preg_t     rat_psrc1;
  logic      rat_busy0;
  logic      rat_busy1;
  logic      wb_hit0;
  logic      wb_hit1;

  // ================================================
  // request register
  // ================================================
  // empty free list blocks every request, even those without a destination
  assign req_ready_o = (!valid_q || ren_o.ready) && fl_ready;
  assign accept      = req_valid_i && req_ready_o;
  assign fire_out    = valid_q && ren_o.ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (fire_out) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      src0_q  <= req_src0_i;
      src1_q  <= req_src1_i;
      dest_q  <= req_dest_i;
      tag_q   <= req_tag_i;
      pdest_q <= (req_dest_i != '0) ? fl_preg : '0;
    end
  end

  free_list i_free_list (
    .clk           (clk),
    .rst_n         (rst_n),
    .alloc_i       (accept && (req_dest_i != '0)),
    .alloc_ready_o (fl_ready),
    .alloc_preg_o  (fl_preg),
    .free_valid_i  (free_valid_i),
    .free_preg_i   (free_preg_i)
  );

  // ================================================
  // rename lookup and entry assembly
  // ================================================
  assign dest_nz = (dest_q != '0);

  register_alias_table i_rat (
    .clk          (clk),
    .rst_n        (rst_n),
    .src0_i       (src0_q),
    .src1_i       (src1_q),
    .dest_i       (dest_q),
    .update_i     (fire_out && dest_nz),
    .new_preg_i   (pdest_q),
    .wb_valid_i   (wb_valid_i),
    .wb_preg_i    (wb_preg_i),
    .psrc0_o      (rat_psrc0),
    .psrc1_o      (rat_psrc1),
    .old_pdest_o  (ren_o.old_pdest),
    .psrc0_busy_o (rat_busy0),
    .psrc1_busy_o (rat_busy1)
  );

  // writeback in the same cycle as the transfer would miss the queue wakeup
  always_comb begin
    wb_hit0 = 1'b0;
    wb_hit1 = 1'b0;
    for (int j = 0; j < WB_WIDTH; j++) begin
      if (wb_valid_i[j] && wb_preg_i[j] == rat_psrc0) begin
        wb_hit0 = 1'b1;
      end
      if (wb_valid_i[j] && wb_preg_i[j] == rat_psrc1) begin
        wb_hit1 = 1'b1;
      end
    end
  end

  assign ren_o.valid      = valid_q;
  assign ren_o.psrc0      = (src0_q == '0) ? '0 : rat_psrc0;
  assign ren_o.psrc1      = (src1_q == '0) ? '0 : rat_psrc1;
  assign ren_o.src0_rdy   = (src0_q == '0) || !rat_busy0 || wb_hit0;
  assign ren_o.src1_rdy   = (src1_q == '0) || !rat_busy1 || wb_hit1;
  assign ren_o.pdest      = pdest_q;
  assign ren_o.dest_valid = dest_nz;
  assign ren_o.tag        = tag_q;

endmodule

/* dispatch/dispatch_queue.sv */
// in-order dispatch queue, only the head may issue
// QUEUE_DEPTH must be a power of two, 2 or more
// sources wake up on writeback, head issues once both sources are ready
`timescale 1ns/1ps

module dispatch_queue #(
  parameter int QUEUE_DEPTH = 8
) (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  sched_pkg::wb_valid_t                        wb_valid_i,
  input  sched_pkg::preg_t [sched_pkg::WB_WIDTH-1:0]  wb_preg_i,
  rename_if.dst                                       ren_i,
  output logic                                        issue_valid_o,
  input  logic                                        issue_ready_i,
  output sched_pkg::preg_t                            issue_psrc0_o,
  output sched_pkg::preg_t                            issue_psrc1_o,
  output sched_pkg::preg_t                            issue_pdest_o,
  output sched_pkg::preg_t                            issue_old_pdest_o,
  output logic                                        issue_dest_valid_o,
  output sched_pkg::op_tag_t                          issue_tag_o
);
  import sched_pkg::*;

  localparam int AW = $clog2(QUEUE_DEPTH);

  // one extra wrap bit tells full from empty
  logic [AW:0]            wr_ptr_q;
  logic [AW:0]            rd_ptr_q;
  logic [AW-1:0]          head;
  logic                   empty;
  logic                   full;
  logic                   wr_en;
  logic                   rd_en;

  preg_t                  psrc0_q     [QUEUE_DEPTH];
  preg_t                  psrc1_q     [QUEUE_DEPTH];
  preg_t                  pdest_q     [QUEUE_DEPTH];
  preg_t                  old_pdest_q [QUEUE_DEPTH];
  logic                   dest_vld_q  [QUEUE_DEPTH];
  op_tag_t                tag_q       [QUEUE_DEPTH];
  logic [QUEUE_DEPTH-1:0] rdy0_q;
  logic [QUEUE_DEPTH-1:0] rdy1_q;

  assign head  = rd_ptr_q[AW-1:0];
  assign empty = (wr_ptr_q == rd_ptr_q);
  assign full  = (wr_ptr_q == {~rd_ptr_q[AW], rd_ptr_q[AW-1:0]});

  assign ren_i.ready = !full;
  assign wr_en       = ren_i.valid && !full;
  assign rd_en       = issue_valid_o && issue_ready_i;

  // ================================================
  // pointers and ready bits
  // ================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      rdy0_q   <= '0;
      rdy1_q   <= '0;
    end else begin
      // wakeup across all slots, stale slots are harmless
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
        for (int j = 0; j < WB_WIDTH; j++) begin
          if (wb_valid_i[j] && wb_preg_i[j] == psrc0_q[i]) begin
            rdy0_q[i] <= 1'b1;
          end
          if (wb_valid_i[j] && wb_preg_i[j] == psrc1_q[i]) begin
            rdy1_q[i] <= 1'b1;
          end
        end
      end
      // the slot being written is free, so its own readiness wins
      if (wr_en) begin
        rdy0_q[wr_ptr_q[AW-1:0]] <= ren_i.src0_rdy;
        rdy1_q[wr_ptr_q[AW-1:0]] <= ren_i.src1_rdy;
        wr_ptr_q                 <= wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // payload storage
  always_ff @(posedge clk) begin
    if (wr_en) begin
      psrc0_q[wr_ptr_q[AW-1:0]]     <= ren_i.psrc0;
      psrc1_q[wr_ptr_q[AW-1:0]]     <= ren_i.psrc1;
      pdest_q[wr_ptr_q[AW-1:0]]     <= ren_i.pdest;
      old_pdest_q[wr_ptr_q[AW-1:0]] <= ren_i.old_pdest;
      dest_vld_q[wr_ptr_q[AW-1:0]]  <= ren_i.dest_valid;
      tag_q[wr_ptr_q[AW-1:0]]       <= ren_i.tag;
    end
  end

  // ================================================
  // head issue
  // ================================================
  // ready bits only ever rise, so a waiting head keeps valid high
  assign issue_valid_o      = !empty && rdy0_q[head] && rdy1_q[head];
  assign issue_psrc0_o      = psrc0_q[head];
  assign issue_psrc1_o      = psrc1_q[head];
  assign issue_pdest_o      = pdest_q[head];
  assign issue_old_pdest_o  = old_pdest_q[head];
  assign issue_dest_valid_o = dest_vld_q[head];
  assign issue_tag_o        = tag_q[head];

  // rename stage must hold its entry while the queue is full
  a_hold_while_full: assert property (
    @(posedge clk) disable iff (!rst_n)
    ren_i.valid && full |=> ren_i.valid && $stable(ren_i.tag) && $stable(ren_i.pdest)
  );

endmodule

/* src/scheduler_top.sv */
// rename and dispatch front end, one instruction per cycle
// free port has no ready, commit must only free registers it really retires
// issue latency depends on writebacks, watch issue_valid_o
`timescale 1ns/1ps

module scheduler_top #(
  parameter int QUEUE_DEPTH = 8
) (
  input  logic                                        clk,
  input  logic                                        rst_n,
  // request
  input  logic                                        req_valid_i,
  output logic                                        req_ready_o,
  input  sched_pkg::arch_reg_t                        req_src0_i,
  input  sched_pkg::arch_reg_t                        req_src1_i,
  input  sched_pkg::arch_reg_t                        req_dest_i,
  input  sched_pkg::op_tag_t                          req_tag_i,
  // writeback broadcast
  input  sched_pkg::wb_valid_t                        wb_valid_i,
  input  sched_pkg::preg_t [sched_pkg::WB_WIDTH-1:0]  wb_preg_i,
  // free from commit
  input  logic                                        free_valid_i,
  input  sched_pkg::preg_t                            free_preg_i,
  // issue
  output logic                                        issue_valid_o,
  input  logic                                        issue_ready_i,
  output sched_pkg::preg_t                            issue_psrc0_o,
  output sched_pkg::preg_t                            issue_psrc1_o,
  output sched_pkg::preg_t                            issue_pdest_o,
  output sched_pkg::preg_t                            issue_old_pdest_o,
  output logic                                        issue_dest_valid_o,
  output sched_pkg::op_tag_t                          issue_tag_o
);

  rename_if ren_bus ();

  rename_stage i_rename_stage (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_src0_i   (req_src0_i),
    .req_src1_i   (req_src1_i),
    .req_dest_i   (req_dest_i),
    .req_tag_i    (req_tag_i),
    .wb_valid_i   (wb_valid_i),
    .wb_preg_i    (wb_preg_i),
    .free_valid_i (free_valid_i),
    .free_preg_i  (free_preg_i),
    .ren_o        (ren_bus.src)
  );

  dispatch_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) i_dispatch_queue (
    .clk                (clk),
    .rst_n              (rst_n),
    .wb_valid_i         (wb_valid_i),
    .wb_preg_i          (wb_preg_i),
    .ren_i              (ren_bus.dst),
    .issue_valid_o      (issue_valid_o),
    .issue_ready_i      (issue_ready_i),
    .issue_psrc0_o      (issue_psrc0_o),
    .issue_psrc1_o      (issue_psrc1_o),
    .issue_pdest_o      (issue_pdest_o),
    .issue_old_pdest_o  (issue_old_pdest_o),
    .issue_dest_valid_o (issue_dest_valid_o),
    .issue_tag_o        (issue_tag_o)
  );

endmodule

/* verification/tb_clock_gen.sv */
// testbench clock of 40 ns period
// reset held low for 10 cycles, released on a falling edge
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

/* verification/tb_checker.sv */
// reference model of rename, free list and busy set, fed from the DUT ports
// compares every issue against the values expected at acceptance
`timescale 1ns/1ps

module tb_checker (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        window_i,
  input  logic                                        req_valid_i,
  input  logic                                        req_ready_i,
  input  sched_pkg::arch_reg_t                        req_src0_i,
  input  sched_pkg::arch_reg_t                        req_src1_i,
  input  sched_pkg::arch_reg_t                        req_dest_i,
  input  sched_pkg::op_tag_t                          req_tag_i,
  input  sched_pkg::wb_valid_t                        wb_valid_i,
  input  sched_pkg::preg_t [sched_pkg::WB_WIDTH-1:0]  wb_preg_i,
  input  logic                                        free_valid_i,
  input  sched_pkg::preg_t                            free_preg_i,
  input  logic                                        issue_valid_i,
  input  logic                                        issue_ready_i,
  input  sched_pkg::preg_t                            issue_psrc0_i,
  input  sched_pkg::preg_t                            issue_psrc1_i,
  input  sched_pkg::preg_t                            issue_pdest_i,
  input  sched_pkg::preg_t                            issue_old_pdest_i,
  input  logic                                        issue_dest_valid_i,
  input  sched_pkg::op_tag_t                          issue_tag_i,
  output int                                          err_cnt_o,
  output int                                          issued_cnt_o,
  output logic                                        exhausted_o,
  output logic                                        resumed_o
);
  import sched_pkg::*;

  // entry layout: tag, psrc0, psrc1, pdest, old_pdest, dest_valid
  typedef logic [40:0] entry_t;

  preg_t  map_m [ARCH_REG_NUM];
  logic   busy_m [PHY_REG_NUM];
  preg_t  fl_m[$];
  entry_t exp_q[$];
  logic   hold_prev;
  entry_t prev_pl;
  entry_t act;
  entry_t exp_e;

  task automatic report_fail(input string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    err_cnt_o++;
  endtask

  task automatic reset_model();
    for (int r = 0; r < ARCH_REG_NUM; r++) begin
      map_m[r] = preg_t'(r);
    end
    for (int p = 0; p < PHY_REG_NUM; p++) begin
      busy_m[p] = 1'b0;
    end
    fl_m.delete();
    for (int p = ARCH_REG_NUM; p < PHY_REG_NUM; p++) begin
      fl_m.push_back(preg_t'(p));
    end
    exp_q.delete();
    hold_prev = 1'b0;
  endtask

  task automatic model_accept();
    preg_t ps0;
    preg_t ps1;
    preg_t pd;
    preg_t old;
    ps0 = (req_src0_i == '0) ? '0 : map_m[req_src0_i];
    ps1 = (req_src1_i == '0) ? '0 : map_m[req_src1_i];
    old = map_m[req_dest_i];
    pd  = '0;
    if (req_dest_i != '0) begin
      if (fl_m.size() == 0) begin
        report_fail("request with destination accepted while free list is empty");
      end else begin
        pd = fl_m.pop_front();
        map_m[req_dest_i] = pd;
        busy_m[pd] = 1'b1;
      end
    end
    exp_q.push_back({req_tag_i, ps0, ps1, pd, old, req_dest_i != '0});
  endtask

  initial begin
    err_cnt_o    = 0;
    issued_cnt_o = 0;
    exhausted_o  = 1'b0;
    resumed_o    = 1'b0;
  end

  // ==================================================
  // per-edge comparison
  // ==================================================
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reset_model();
    end else begin
      act = {issue_tag_i, issue_psrc0_i, issue_psrc1_i, issue_pdest_i,
             issue_old_pdest_i, issue_dest_valid_i};

      // stalled issue must keep valid and payload
      if (hold_prev && (!issue_valid_i || act != prev_pl)) begin
        report_fail($sformatf("issue dropped or changed under back-pressure, was %h now %h",
                              prev_pl, act));
      end
      hold_prev = issue_valid_i && !issue_ready_i;
      prev_pl   = act;

      if (issue_valid_i && issue_ready_i) begin
        if (exp_q.size() == 0) begin
          report_fail("issue with no accepted request outstanding");
        end else begin
          exp_e = exp_q.pop_front();
          if (act != exp_e) begin
            report_fail($sformatf("issue mismatch, expected %h got %h", exp_e, act));
          end
          if (busy_m[issue_psrc0_i] || busy_m[issue_psrc1_i]) begin
            report_fail($sformatf("tag %h issued with a busy source", issue_tag_i));
          end
        end
        issued_cnt_o++;
      end

      for (int j = 0; j < WB_WIDTH; j++) begin
        if (wb_valid_i[j]) begin
          busy_m[wb_preg_i[j]] = 1'b0;
        end
      end

      if (fl_m.size() == 0) begin
        if (req_ready_i) begin
          report_fail("req_ready_o high while the free list is empty");
        end
        if (window_i) begin
          exhausted_o = 1'b1;
        end
      end

      if (req_valid_i && req_ready_i) begin
        if (exhausted_o && !window_i) begin
          resumed_o = 1'b1;
        end
        model_accept();
      end

      if (free_valid_i) begin
        fl_m.push_back(free_preg_i);
      end
    end
  end

endmodule

/* verification/tb_top.sv */
// random request stream into the scheduler plus writeback and commit emulation
// frees follow writebacks with a fixed lag so a register is never reused early
// one window of 60 cycles withholds frees to drain the free list
`timescale 1ns/1ps

module tb_top;
  import sched_pkg::*;

  localparam int REQ_NUM    = 400;
  localparam int TIMEOUT    = REQ_NUM * 30;
  localparam int WIN_START  = 300;
  localparam int WIN_LEN    = 60;
  localparam int FREE_LAG   = 10;

  logic                       clk;
  logic                       rst_n;
  logic                       req_valid;
  logic                       req_ready;
  arch_reg_t                  req_src0;
  arch_reg_t                  req_src1;
  arch_reg_t                  req_dest;
  op_tag_t                    req_tag;
  wb_valid_t                  wb_valid;
  preg_t [WB_WIDTH-1:0]       wb_preg;
  logic                       free_valid;
  preg_t                      free_preg;
  logic                       issue_valid;
  logic                       issue_ready;
  preg_t                      issue_psrc0;
  preg_t                      issue_psrc1;
  preg_t                      issue_pdest;
  preg_t                      issue_old_pdest;
  logic                       issue_dest_valid;
  op_tag_t                    issue_tag;

  logic [31:0] rand_state;
  int          cyc;
  int          accepted;
  logic        req_fire;
  logic        in_window;
  int          err_cnt;
  int          issued_cnt;
  logic        exhausted;
  logic        resumed;
  logic        timed_out;

  // issued instructions waiting for a writeback slot and then a free
  preg_t iss_pd[$];
  preg_t iss_old[$];
  int    wb_due[$];
  preg_t wb_reg[$];
  int    fr_due[$];
  preg_t fr_reg[$];

  tb_clock_gen i_clock_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  scheduler_top #(
    .QUEUE_DEPTH (8)
  ) i_dut (
    .clk                (clk),
    .rst_n              (rst_n),
    .req_valid_i        (req_valid),
    .req_ready_o        (req_ready),
    .req_src0_i         (req_src0),
    .req_src1_i         (req_src1),
    .req_dest_i         (req_dest),
    .req_tag_i          (req_tag),
    .wb_valid_i         (wb_valid),
    .wb_preg_i          (wb_preg),
    .free_valid_i       (free_valid),
    .free_preg_i        (free_preg),
    .issue_valid_o      (issue_valid),
    .issue_ready_i      (issue_ready),
    .issue_psrc0_o      (issue_psrc0),
    .issue_psrc1_o      (issue_psrc1),
    .issue_pdest_o      (issue_pdest),
    .issue_old_pdest_o  (issue_old_pdest),
    .issue_dest_valid_o (issue_dest_valid),
    .issue_tag_o        (issue_tag)
  );

  tb_checker i_checker (
    .clk                (clk),
    .rst_n              (rst_n),
    .window_i           (in_window),
    .req_valid_i        (req_valid),
    .req_ready_i        (req_ready),
    .req_src0_i         (req_src0),
    .req_src1_i         (req_src1),
    .req_dest_i         (req_dest),
    .req_tag_i          (req_tag),
    .wb_valid_i         (wb_valid),
    .wb_preg_i          (wb_preg),
    .free_valid_i       (free_valid),
    .free_preg_i        (free_preg),
    .issue_valid_i      (issue_valid),
    .issue_ready_i      (issue_ready),
    .issue_psrc0_i      (issue_psrc0),
    .issue_psrc1_i      (issue_psrc1),
    .issue_pdest_i      (issue_pdest),
    .issue_old_pdest_i  (issue_old_pdest),
    .issue_dest_valid_i (issue_dest_valid),
    .issue_tag_i        (issue_tag),
    .err_cnt_o          (err_cnt),
    .issued_cnt_o       (issued_cnt),
    .exhausted_o        (exhausted),
    .resumed_o          (resumed)
  );

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  // ==================================================
  // edge sampling
  // ==================================================
  always @(posedge clk) begin
    if (rst_n) begin
      cyc      = cyc + 1;
      req_fire = req_valid && req_ready;
      if (req_fire) begin
        accepted = accepted + 1;
      end
      if (issue_valid && issue_ready && issue_dest_valid) begin
        iss_pd.push_back(issue_pdest);
        iss_old.push_back(issue_old_pdest);
      end
    end
  end

  // ==================================================
  // stimulus on the falling edge
  // ==================================================
  task automatic schedule_issued();
    int d;
    while (iss_pd.size() > 0) begin
      d = 1 + int'(next_rand() >> 1) % 6;
      wb_due.push_back(cyc + d);
      wb_reg.push_back(iss_pd.pop_front());
      fr_due.push_back(cyc + d + FREE_LAG);
      fr_reg.push_back(iss_old.pop_front());
    end
  endtask

  task automatic drive_writebacks();
    int i;
    int lane;
    int first;
    i     = 0;
    lane  = 0;
    first = int'(next_rand() >> 1) % WB_WIDTH;
    wb_valid = '0;
    while (i < wb_due.size() && lane < WB_WIDTH) begin
      if (wb_due[i] <= cyc) begin
        wb_valid[(first + lane) % WB_WIDTH] = 1'b1;
        wb_preg[(first + lane) % WB_WIDTH]  = wb_reg[i];
        wb_due.delete(i);
        wb_reg.delete(i);
        lane++;
      end else begin
        i++;
      end
    end
  endtask

  task automatic drive_free();
    free_valid = 1'b0;
    if (!in_window) begin
      for (int i = 0; i < fr_due.size(); i++) begin
        if (fr_due[i] <= cyc) begin
          free_valid = 1'b1;
          free_preg  = fr_reg[i];
          fr_due.delete(i);
          fr_reg.delete(i);
          break;
        end
      end
    end
  endtask

  task automatic drive_request();
    logic [31:0] r;
    if (req_valid && req_fire) begin
      req_valid = 1'b0;
    end
    r = next_rand();
    if (!req_valid && accepted < REQ_NUM && r[1:0] != 2'b00) begin
      req_valid = 1'b1;
      req_src0  = arch_reg_t'(r[12:8]);
      req_src1  = arch_reg_t'(r[17:13]);
      req_dest  = arch_reg_t'(r[22:18]);
      req_tag   = op_tag_t'(next_rand() >> 16);
    end
    r = next_rand();
    issue_ready = (r[9:8] != 2'b00);
  endtask

  // stimulus starts after the first clock out of reset
  always @(negedge clk) begin
    if (cyc > 0) begin
      in_window = (cyc >= WIN_START) && (cyc < WIN_START + WIN_LEN);
      schedule_issued();
      drive_writebacks();
      drive_free();
      drive_request();
    end
  end

  // ==================================================
  // run control
  // ==================================================
  initial begin
    rand_state  = 32'h0f59_b700;
    cyc         = 0;
    accepted    = 0;
    req_fire    = 1'b0;
    in_window   = 1'b0;
    timed_out   = 1'b0;
    req_valid   = 1'b0;
    req_src0    = '0;
    req_src1    = '0;
    req_dest    = '0;
    req_tag     = '0;
    wb_valid    = '0;
    wb_preg     = '0;
    free_valid  = 1'b0;
    free_preg   = '0;
    issue_ready = 1'b0;

    @(posedge rst_n);
    while (issued_cnt < REQ_NUM && cyc < TIMEOUT) begin
      @(negedge clk);
    end
    timed_out = (issued_cnt < REQ_NUM);
    repeat (4) @(negedge clk);

    if (timed_out) begin
      $display("timeout after %0d cycles, only %0d of %0d requests issued",
               cyc, issued_cnt, REQ_NUM);
    end
    if (!exhausted) begin
      $display("free list never ran empty during the free-withholding window");
    end
    if (!resumed) begin
      $display("no request was accepted after frees resumed");
    end
    $display("errors: %0d, accepted: %0d, issued: %0d, cycles: %0d",
             err_cnt, accepted, issued_cnt, cyc);
    if (err_cnt == 0 && !timed_out && issued_cnt == REQ_NUM && exhausted && resumed) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* all.f */
common/sched_pkg.sv
common/rename_if.sv
rename/free_list.sv
rename/register_alias_table.sv
rename/rename_stage.sv
dispatch/dispatch_queue.sv
src/scheduler_top.sv
verification/tb_clock_gen.sv
verification/tb_checker.sv
verification/tb_top.sv

/* Makefile */
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f all.f --top-module tb_top -o sim

run: build
	./obj_dir/sim | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG)

lint:
	verilator --lint-only --timing -f all.f --top-module tb_top
	verilator --lint-only -f all.f --top-module scheduler_top

clean:
	rm -rf obj_dir $(LOG)
